// File: all.f
+incdir+.
dataPathPkg.sv
registerFile.sv
multiplier.sv
alu.sv
dataPath.sv
dataPath_sva.sv
dataPathTb.sv

// File: alu.sv
// ALU with single-cycle operations on Y and the bus plus the sequential multiplier
`default_nettype none

`include "dataPath_macros.svh"

module alu (
   input  logic                      Clock,
   input  logic                      reset,
   input  dataPathPkg::aluOp         opSelect,
   input  logic                      start,
   input  logic [`DATA_WIDTH-1:0]    a,
   input  logic [`DATA_WIDTH-1:0]    b,
   output logic [2*`DATA_WIDTH-1:0]  result,
   output logic                      finished
);

   import dataPathPkg::*;

   logic                      mulStart;
   logic [2*`DATA_WIDTH-1:0]  product;
   logic [`DATA_WIDTH-1:0]    lowResult;
   logic [4:0]                shiftAmount;

   assign shiftAmount = b[4:0];

   // only a multiply opcode may launch the multiplier
   assign mulStart = start && (opSelect == opMul);

   multiplier multiplier_i (
      .Clock        (Clock),
      .reset        (reset),
      .start        (mulStart),
      .multiplicand (a),
      .multiplier   (b),
      .product      (product),
      .finished     (finished)
   );

   // single-cycle operations, all 32 bits wide
   always_comb begin
      case (opSelect)
         opAdd:   lowResult = a + b;
         opSub:   lowResult = a - b;
         opAnd:   lowResult = a & b;
         opOr:    lowResult = a | b;
         opShl:   lowResult = a << shiftAmount;
         opShr:   lowResult = a >> shiftAmount;   // zero fill
         opNeg:   lowResult = -b;
         opNot:   lowResult = ~b;
         default: lowResult = '0;
      endcase
   end

   // product is held by the multiplier until the next completion
   always_comb begin
      if (opSelect == opMul) begin
         result = product;
      end else begin
         result = {{`DATA_WIDTH{1'b0}}, lowResult};   // upper half zero
      end
   end

endmodule

`default_nettype wire

// File: dataPath.sv
// single-bus datapath: bus multiplexer, PC, IR, Y, Z, HI, LO, MAR, MDR, register file and ALU
`default_nettype none

`include "dataPath_macros.svh"

module dataPath (
   input  logic                      Clock,
   input  logic                      reset,
   // bus sources
   input  logic                      rfOut,
   input  logic                      pcOut,
   input  logic                      irOut,
   input  logic                      yOut,
   input  logic                      zLoOut,
   input  logic                      zHiOut,
   input  logic                      marOut,
   input  logic                      hiOut,
   input  logic                      loOut,
   input  logic                      mdrOut,
   // register loads
   input  logic                      rfIn,
   input  logic                      pcIn,
   input  logic                      irIn,
   input  logic                      yIn,
   input  logic                      zIn,
   input  logic                      marIn,
   input  logic                      hiIn,
   input  logic                      loIn,
   input  logic                      mdrIn,
   input  logic                      read,
   input  logic                      incPc,
   input  logic [`REG_SEL_WIDTH-1:0] rfSelect,
   input  dataPathPkg::aluOp         opSelect,
   input  logic                      start,
   input  logic [`DATA_WIDTH-1:0]    memDataIn,
   output logic [`DATA_WIDTH-1:0]    bus,
   output logic [`DATA_WIDTH-1:0]    address,
   output logic                      finished
);

   logic [`DATA_WIDTH-1:0]    pc;
   logic [`DATA_WIDTH-1:0]    ir;
   logic [`DATA_WIDTH-1:0]    y;
   logic [2*`DATA_WIDTH-1:0]  z;
   logic [`DATA_WIDTH-1:0]    hi;
   logic [`DATA_WIDTH-1:0]    lo;
   logic [`DATA_WIDTH-1:0]    mar;
   logic [`DATA_WIDTH-1:0]    mdr;
   logic [`DATA_WIDTH-1:0]    rfData;
   logic [2*`DATA_WIDTH-1:0]  aluResult;

   // AND-OR multiplexer, zero when no strobe is up
   assign bus = ({`DATA_WIDTH{rfOut}}  & rfData)
              | ({`DATA_WIDTH{pcOut}}  & pc)
              | ({`DATA_WIDTH{irOut}}  & ir)
              | ({`DATA_WIDTH{yOut}}   & y)
              | ({`DATA_WIDTH{zLoOut}} & z[`DATA_WIDTH-1:0])
              | ({`DATA_WIDTH{zHiOut}} & z[2*`DATA_WIDTH-1:`DATA_WIDTH])
              | ({`DATA_WIDTH{marOut}} & mar)
              | ({`DATA_WIDTH{hiOut}}  & hi)
              | ({`DATA_WIDTH{loOut}}  & lo)
              | ({`DATA_WIDTH{mdrOut}} & mdr);

   registerFile registerFile_i (
      .Clock       (Clock),
      .reset       (reset),
      .writeEnable (rfIn),
      .select      (rfSelect),
      .writeData   (bus),
      .readData    (rfData)
   );

   alu alu_i (
      .Clock    (Clock),
      .reset    (reset),
      .opSelect (opSelect),
      .start    (start),
      .a        (y),
      .b        (bus),
      .result   (aluResult),
      .finished (finished)
   );

   // PC increment wins over a bus load
   always_ff @(posedge Clock) begin
      if (reset) begin
         pc <= '0;
      end else if (incPc) begin
         pc <= pc + 1'b1;
      end else if (pcIn) begin
         pc <= bus;
      end
   end

   // memory data takes priority over the bus for MDR
   always_ff @(posedge Clock) begin
      if (reset) begin
         mdr <= '0;
      end else if (read) begin
         mdr <= memDataIn;
      end else if (mdrIn) begin
         mdr <= bus;
      end
   end

   always_ff @(posedge Clock) begin
      if (reset) begin
         z <= '0;
      end else if (zIn) begin
         z <= aluResult;   // full 64-bit ALU result
      end
   end

   // plain bus-loaded registers
   always_ff @(posedge Clock) begin
      if (reset) begin
         ir  <= '0;
         y   <= '0;
         hi  <= '0;
         lo  <= '0;
         mar <= '0;
      end else begin
         if (irIn)  ir  <= bus;
         if (yIn)   y   <= bus;
         if (hiIn)  hi  <= bus;
         if (loIn)  lo  <= bus;
         if (marIn) mar <= bus;
      end
   end

   assign address = mar;   // straight to memory

endmodule

`default_nettype wire

// File: dataPathPkg.sv
// ALU opcode enum and multiplier state enum
`default_nettype none

`include "dataPath_macros.svh"

package dataPathPkg;

   // ALU operations, a is Y and b is the bus
   typedef enum logic [`OP_WIDTH-1:0] {
      opAdd = 4'd0,   // a + b
      opSub = 4'd1,   // a - b
      opAnd = 4'd2,
      opOr  = 4'd3,
      opShl = 4'd4,   // a << b[4:0]
      opShr = 4'd5,   // logical a >> b[4:0]
      opNeg = 4'd6,   // -b
      opNot = 4'd7,   // ~b
      opMul = 4'd8    // unsigned a * b, 64 bits
   } aluOp;

   // sequential multiplier control
   typedef enum logic [1:0] {
      mulIdle = 2'd0,
      mulBusy = 2'd1,
      mulDone = 2'd2
   } multState;

endpackage

`default_nettype wire

// File: dataPathTb.sv
// testbench for the single-bus datapath: stimulus, register model, compare tasks, timeout
`default_nettype none

`include "dataPath_macros.svh"

module dataPathTb;

   import dataPathPkg::*;

   // bus sources, bit index into outStrobes
   localparam int SrcRf  = 0;
   localparam int SrcPc  = 1;
   localparam int SrcIr  = 2;
   localparam int SrcY   = 3;
   localparam int SrcZLo = 4;
   localparam int SrcZHi = 5;
   localparam int SrcMar = 6;
   localparam int SrcHi  = 7;
   localparam int SrcLo  = 8;
   localparam int SrcMdr = 9;
   localparam int NumSrc = 10;
   // bus destinations, bit index into inStrobes
   localparam int DstRf   = 0;
   localparam int DstPc   = 1;
   localparam int DstIr   = 2;
   localparam int DstY    = 3;
   localparam int DstMar  = 4;
   localparam int DstHi   = 5;
   localparam int DstLo   = 6;
   localparam int DstMdr  = 7;
   localparam int DstNone = 8;

   localparam int NumTrans      = 200;
   localparam int CyclesPerTrans = 60;
   localparam int TimeoutCycles = NumTrans * CyclesPerTrans;

   logic                      Clock;
   logic                      reset;
   logic [NumSrc-1:0]         outStrobes;
   logic [7:0]                inStrobes;
   logic                      zIn;
   logic                      read;
   logic                      incPc;
   logic                      start;
   logic [`REG_SEL_WIDTH-1:0] rfSelect;
   aluOp                      opSelect;
   logic [`DATA_WIDTH-1:0]    memDataIn;
   logic [`DATA_WIDTH-1:0]    bus;
   logic [`DATA_WIDTH-1:0]    address;
   logic                      finished;

   integer seed;
   int     errorCount;
   int     cycleCount;

   // reference model of every register
   logic [`DATA_WIDTH-1:0]    rfM [`REG_COUNT];
   logic [`DATA_WIDTH-1:0]    pcM, irM, yM, hiM, loM, marM, mdrM;
   logic [2*`DATA_WIDTH-1:0]  zM;

   dataPath dataPath_i (
      .Clock     (Clock),
      .reset     (reset),
      .rfOut     (outStrobes[SrcRf]),
      .pcOut     (outStrobes[SrcPc]),
      .irOut     (outStrobes[SrcIr]),
      .yOut      (outStrobes[SrcY]),
      .zLoOut    (outStrobes[SrcZLo]),
      .zHiOut    (outStrobes[SrcZHi]),
      .marOut    (outStrobes[SrcMar]),
      .hiOut     (outStrobes[SrcHi]),
      .loOut     (outStrobes[SrcLo]),
      .mdrOut    (outStrobes[SrcMdr]),
      .rfIn      (inStrobes[DstRf]),
      .pcIn      (inStrobes[DstPc]),
      .irIn      (inStrobes[DstIr]),
      .yIn       (inStrobes[DstY]),
      .zIn       (zIn),
      .marIn     (inStrobes[DstMar]),
      .hiIn      (inStrobes[DstHi]),
      .loIn      (inStrobes[DstLo]),
      .mdrIn     (inStrobes[DstMdr]),
      .read      (read),
      .incPc     (incPc),
      .rfSelect  (rfSelect),
      .opSelect  (opSelect),
      .start     (start),
      .memDataIn (memDataIn),
      .bus       (bus),
      .address   (address),
      .finished  (finished)
   );

   initial begin
      Clock = 1'b0;
      forever #50 Clock = ~Clock;
   end

   always @(posedge Clock) begin
      cycleCount <= cycleCount + 1;
      if (cycleCount >= TimeoutCycles) begin
         $display("timeout: the run did not complete within %0d cycles", TimeoutCycles);
         $display("ERRORS FOUND");
         $fatal(1, "stopped by the cycle limit");
      end
   end

   always @(posedge Clock) begin
      if (dataPath_i.dataPathSva_i.failCount != 0) begin
         $display("a bound assertion on the datapath failed at time %0t", $time);
         $display("ERRORS FOUND");
         $fatal(1, "stopped by a failed assertion");
      end
   end

   // expected 64-bit ALU result from the opcode rules
   function automatic logic [2*`DATA_WIDTH-1:0] expectedResult(input aluOp op,
         input logic [`DATA_WIDTH-1:0] a, input logic [`DATA_WIDTH-1:0] b);
      logic [4:0] sh;
      sh = b[4:0];
      case (op)
         opAdd:   return {{`DATA_WIDTH{1'b0}}, a + b};
         opSub:   return {{`DATA_WIDTH{1'b0}}, a - b};
         opAnd:   return {{`DATA_WIDTH{1'b0}}, a & b};
         opOr:    return {{`DATA_WIDTH{1'b0}}, a | b};
         opShl:   return {{`DATA_WIDTH{1'b0}}, a << sh};
         opShr:   return {{`DATA_WIDTH{1'b0}}, a >> sh};
         opNeg:   return {{`DATA_WIDTH{1'b0}}, -b};
         opNot:   return {{`DATA_WIDTH{1'b0}}, ~b};
         opMul:   return {{`DATA_WIDTH{1'b0}}, a} * {{`DATA_WIDTH{1'b0}}, b};
         default: return '0;
      endcase
   endfunction

   function automatic logic [`DATA_WIDTH-1:0] modelBus(input int src,
         input logic [`REG_SEL_WIDTH-1:0] sel);
      case (src)
         SrcRf:   return rfM[sel];
         SrcPc:   return pcM;
         SrcIr:   return irM;
         SrcY:    return yM;
         SrcZLo:  return zM[`DATA_WIDTH-1:0];
         SrcZHi:  return zM[2*`DATA_WIDTH-1:`DATA_WIDTH];
         SrcMar:  return marM;
         SrcHi:   return hiM;
         SrcLo:   return loM;
         SrcMdr:  return mdrM;
         default: return '0;
      endcase
   endfunction

   function automatic void writeModel(input int dst, input logic [`REG_SEL_WIDTH-1:0] sel,
         input logic [`DATA_WIDTH-1:0] value);
      case (dst)
         DstRf:   rfM[sel] = value;
         DstPc:   pcM = value;
         DstIr:   irM = value;
         DstY:    yM = value;
         DstMar:  marM = value;
         DstHi:   hiM = value;
         DstLo:   loM = value;
         DstMdr:  mdrM = value;
         default: ;
      endcase
   endfunction

   task automatic checkWord(input string what, input logic [`DATA_WIDTH-1:0] actual,
         input logic [`DATA_WIDTH-1:0] expected);
      if (actual !== expected) begin
         errorCount++;
         $display("FAIL time %0t: %s is %h, expected %h", $time, what, actual, expected);
         $display("ERRORS FOUND");
         $fatal(1, "stopping at the first mismatch");
      end
   endtask

   task automatic checkOp(input aluOp op, input logic [`DATA_WIDTH-1:0] a,
         input logic [`DATA_WIDTH-1:0] b, input logic [2*`DATA_WIDTH-1:0] actual);
      logic [2*`DATA_WIDTH-1:0] expected;
      expected = expectedResult(op, a, b);
      if (actual !== expected) begin
         errorCount++;
         $display("FAIL time %0t: %s of %h and %h gave %h, expected %h",
                  $time, op.name(), a, b, actual, expected);
         $display("ERRORS FOUND");
         $fatal(1, "stopping at the first mismatch");
      end
   endtask

   task automatic driveIdle();
      outStrobes <= '0;
      inStrobes  <= '0;
      zIn        <= 1'b0;
      read       <= 1'b0;
      incPc      <= 1'b0;
      start      <= 1'b0;
   endtask

   task automatic idleCycle();
      @(posedge Clock);
      driveIdle();
      @(negedge Clock);
   endtask

   // one bus cycle from src to dst, bus checked mid-cycle
   task automatic transfer(input int src, input int dst,
         input logic [`REG_SEL_WIDTH-1:0] sel, output logic [`DATA_WIDTH-1:0] value);
      logic [`DATA_WIDTH-1:0] expected;
      @(posedge Clock);
      driveIdle();
      rfSelect <= sel;
      outStrobes[src] <= 1'b1;
      if (dst != DstNone) inStrobes[dst] <= 1'b1;
      expected = modelBus(src, sel);
      @(negedge Clock);
      checkWord("bus", bus, expected);
      value = bus;
      writeModel(dst, sel, expected);
   endtask

   task automatic memRead(input logic [`DATA_WIDTH-1:0] word);
      @(posedge Clock);
      driveIdle();
      read <= 1'b1;
      inStrobes[DstMdr] <= 1'b1;   // memory data wins over the bus
      outStrobes[SrcY] <= 1'b1;
      memDataIn <= word;
      @(negedge Clock);
      checkWord("bus under yOut", bus, yM);
      mdrM = word;
   endtask

   // Y op bus into Z; a multiply waits for the finished pulse first
   task automatic aluStep(input aluOp op, input logic [`REG_SEL_WIDTH-1:0] sel);
      logic [`DATA_WIDTH-1:0] a;
      logic [`DATA_WIDTH-1:0] b;
      a = yM;
      b = rfM[sel];
      @(posedge Clock);
      driveIdle();
      rfSelect <= sel;
      outStrobes[SrcRf] <= 1'b1;
      opSelect <= op;
      if (op == opMul) start <= 1'b1;
      else zIn <= 1'b1;
      @(negedge Clock);
      checkWord("ALU operand", bus, b);
      if (op == opMul) begin
         @(posedge Clock);
         driveIdle();
         do @(negedge Clock); while (!finished);
         @(posedge Clock);
         driveIdle();
         zIn <= 1'b1;   // product is held after finished
         @(negedge Clock);
      end
      zM = expectedResult(op, a, b);
   endtask

   task automatic pcStep();
      logic [`DATA_WIDTH-1:0] value;
      @(posedge Clock);
      driveIdle();
      incPc <= 1'b1;
      inStrobes[DstPc] <= 1'b1;   // loses to the increment
      outStrobes[SrcMdr] <= 1'b1;
      @(negedge Clock);
      pcM = pcM + 1'b1;
      transfer(SrcPc, DstMar, '0, value);
      idleCycle();
      checkWord("address", address, marM);
      transfer(SrcMar, DstNone, '0, value);
   endtask

   initial begin
      logic [`DATA_WIDTH-1:0]    wordA, wordB, opA, opB, value, hiVal, loVal;
      logic [`REG_SEL_WIDTH-1:0] idxA, idxB;
      aluOp                      op;
      seed       = 32'hf3e3;
      errorCount = 0;
      cycleCount = 0;
      reset      = 1'b1;
      outStrobes = '0;
      inStrobes  = '0;
      zIn        = 1'b0;
      read       = 1'b0;
      incPc      = 1'b0;
      start      = 1'b0;
      rfSelect   = '0;
      opSelect   = opAdd;
      memDataIn  = '0;
      for (int i = 0; i < `REG_COUNT; i++) rfM[i] = '0;
      {pcM, irM, yM, hiM, loM, marM, mdrM} = '0;
      zM = '0;
      repeat (4) @(posedge Clock);
      reset <= 1'b0;

      // every source reads zero after reset
      for (int s = 0; s < NumSrc; s++) begin
         transfer(s, DstNone, $random(seed), value);
      end
      checkWord("address after reset", address, '0);

      for (int t = 0; t < NumTrans; t++) begin
         wordA = $random(seed);
         wordB = $random(seed);
         idxA  = $random(seed);
         idxB  = $random(seed);
         op    = aluOp'($unsigned($random(seed)) % 9);
         memRead(wordA);
         transfer(SrcMdr, DstRf, idxA, value);
         memRead(wordB);
         transfer(SrcMdr, DstRf, idxB, value);
         transfer(SrcRf, DstY, idxA, value);
         opA = yM;
         opB = rfM[idxB];
         aluStep(op, idxB);
         transfer(SrcZLo, DstLo, '0, value);
         transfer(SrcZHi, DstHi, '0, value);
         transfer(SrcLo, DstMdr, '0, loVal);
         transfer(SrcHi, DstIr, '0, hiVal);
         checkOp(op, opA, opB, {hiVal, loVal});
         transfer(SrcIr, DstNone, '0, value);
         transfer(SrcMdr, DstNone, '0, value);
         if ($random(seed) & 1) transfer(SrcMdr, DstPc, '0, value);   // random PC now and then
         pcStep();
      end

      // untouched entries must still hold their model values
      for (int i = 0; i < `REG_COUNT; i++) begin
         transfer(SrcRf, DstNone, i, value);
      end
      idleCycle();

      if (errorCount == 0 && dataPath_i.dataPathSva_i.failCount == 0) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: dataPath_macros.svh
// width, count and opcode-size macros for the single-bus datapath
`ifndef DATAPATH_MACROS_SVH
`define DATAPATH_MACROS_SVH

// word width of the bus and of every register except Z
`define DATA_WIDTH 32

// register file geometry
`define REG_COUNT 16
`define REG_SEL_WIDTH 4

// ALU opcode width
`define OP_WIDTH 4

// shift-add iterations of the multiplier, one per multiplier bit
`define MUL_CYCLES 32

`endif

// File: dataPath_sva.sv
// bound assertions on bus source selection and multiplier start/finished timing
`default_nettype none

`include "dataPath_macros.svh"

module dataPathSva (
   input logic                     Clock,
   input logic                     reset,
   input logic [9:0]               outStrobes,
   input logic                     start,
   input dataPathPkg::aluOp        opSelect,
   input logic                     finished,
   input dataPathPkg::multState    mulState
);

   import dataPathPkg::*;

   logic mulStart;
   int   failCount;   // failed assertions so far, read by the testbench

   assign mulStart = start && (opSelect == opMul);   // same gating as the ALU

   busOneHot: assert property (@(posedge Clock) disable iff (reset)
      $onehot0(outStrobes))
      else begin
         $error("more than one bus source enabled in the same cycle");
         failCount++;
      end

   // a product completes exactly MUL_CYCLES edges after start, for one cycle
   mulTiming: assert property (@(posedge Clock) disable iff (reset)
      (mulStart && mulState != mulBusy) |-> ##(`MUL_CYCLES) finished ##1 !finished)
      else begin
         $error("multiplier finished pulse has wrong timing or length");
         failCount++;
      end

   noStartWhileBusy: assert property (@(posedge Clock) disable iff (reset)
      (mulState == mulBusy) |-> !start)
      else begin
         $error("start asserted while the multiplier is busy");
         failCount++;
      end

endmodule

bind dataPath dataPathSva dataPathSva_i (
   .Clock      (Clock),
   .reset      (reset),
   .outStrobes ({rfOut, pcOut, irOut, yOut, zLoOut, zHiOut, marOut, hiOut, loOut, mdrOut}),
   .start      (start),
   .opSelect   (opSelect),
   .finished   (finished),
   .mulState   (alu_i.multiplier_i.state)
);

`default_nettype wire

// File: multiplier.sv
// sequential shift-add unsigned multiplier with start and finished pulses
`default_nettype none

`include "dataPath_macros.svh"

module multiplier (
   input  logic                       Clock,
   input  logic                       reset,
   input  logic                       start,
   input  logic [`DATA_WIDTH-1:0]     multiplicand,
   input  logic [`DATA_WIDTH-1:0]     multiplier,
   output logic [2*`DATA_WIDTH-1:0]   product,
   output logic                       finished
);

   import dataPathPkg::*;

   localparam int CountWidth = $clog2(`MUL_CYCLES);

   multState                  state;
   logic [2*`DATA_WIDTH-1:0]  mcandShift;    // multiplicand, moves left each step
   logic [`DATA_WIDTH-1:0]    mplierShift;   // multiplier, moves right each step
   logic [2*`DATA_WIDTH-1:0]  accum;
   logic [CountWidth-1:0]     count;         // iterations done so far
   logic [2*`DATA_WIDTH-1:0]  firstTerm;
   logic [2*`DATA_WIDTH-1:0]  partialSum;

   // bit 0 is handled on the start edge, so the last bit lands one edge
   // before finished has to be seen
   assign firstTerm  = multiplier[0] ? {{`DATA_WIDTH{1'b0}}, multiplicand} : '0;
   assign partialSum = accum + (mplierShift[0] ? mcandShift : '0);

   always_ff @(posedge Clock) begin
      if (reset) begin
         state       <= mulIdle;
         mcandShift  <= '0;
         mplierShift <= '0;
         accum       <= '0;
         count       <= '0;
         product     <= '0;
      end else begin
         case (state)
            mulIdle, mulDone: begin
               if (start) begin
                  accum       <= firstTerm;
                  mcandShift  <= {{`DATA_WIDTH{1'b0}}, multiplicand} << 1;
                  mplierShift <= multiplier >> 1;
                  count       <= CountWidth'(1);
                  state       <= mulBusy;
               end else begin
                  state <= mulIdle;   // done lasts a single cycle
               end
            end
            mulBusy: begin             // start is ignored here
               accum       <= partialSum;
               mcandShift  <= mcandShift << 1;
               mplierShift <= mplierShift >> 1;
               count       <= count + 1'b1;
               if (count == CountWidth'(`MUL_CYCLES - 1)) begin
                  product <= partialSum;   // valid in the finished cycle
                  state   <= mulDone;
               end
            end
            default: state <= mulIdle;
         endcase
      end
   end

   assign finished = (state == mulDone);

endmodule

`default_nettype wire

// File: registerFile.sv
// 16-entry register file with one write port and one combinational read port
`default_nettype none

`include "dataPath_macros.svh"

module registerFile (
   input  logic                      Clock,
   input  logic                      reset,
   input  logic                      writeEnable,
   input  logic [`REG_SEL_WIDTH-1:0] select,
   input  logic [`DATA_WIDTH-1:0]    writeData,
   output logic [`DATA_WIDTH-1:0]    readData
);

   logic [`DATA_WIDTH-1:0] regs [`REG_COUNT];

   always_ff @(posedge Clock) begin
      if (reset) begin
         for (int i = 0; i < `REG_COUNT; i++) begin
            regs[i] <= '0;
         end
      end else if (writeEnable) begin
         regs[select] <= writeData;   // same index as the read side
      end
   end

   // read is asynchronous so the entry reaches the bus in the same cycle
   assign readData = regs[select];

endmodule

`default_nettype wire
